// File: compile.f
+incdir+dv
src/nms_pkg.sv
src/row_buffer.sv
src/frame_scanner.sv
src/block_max_tracker.sv
src/band_drain.sv
src/block_nms_top.sv
dv/block_nms_tb.sv

// File: dv/block_nms_cases.svh
`ifndef BLOCK_NMS_CASES_SVH
`define BLOCK_NMS_CASES_SVH

// the columns are width, height, score mode, constant value and gaps on
// height is always a multiple of the block size

localparam int NUM_CASES = 9;

localparam case_t CASES [NUM_CASES] = '{
    '{16,  8, MODE_RANDOM, 8'h00, 0},
    '{16,  8, MODE_CONST,  8'h5a, 0},
    '{12,  4, MODE_ZERO,   8'h00, 0},
    // narrow last block column
    '{13,  8, MODE_RANDOM, 8'h00, 0},
    '{ 7, 12, MODE_RANDOM, 8'h00, 1},
    '{64,  8, MODE_RANDOM, 8'h00, 1},
    '{ 5,  4, MODE_CONST,  8'h01, 1},
    '{64,  4, MODE_RANDOM, 8'h00, 0},
    // much narrower frame right after a full-width one
    '{ 2,  8, MODE_RANDOM, 8'h00, 0}
};

`endif

// File: dv/block_nms_tb.sv
module block_nms_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MODE_RANDOM = 0;
    localparam int MODE_CONST  = 1;
    localparam int MODE_ZERO   = 2;

    typedef struct packed {
        int width;
        int height;
        int mode;
        int value;
        int gaps;
    } case_t;

    `include "block_nms_cases.svh"

    logic            clk;
    logic            rst_n;
    logic            cfg_valid;
    nms_pkg::col_t   cfg_width;
    nms_pkg::row_t   cfg_height;
    logic            in_valid;
    nms_pkg::score_t in_score;
    logic            out_valid;
    nms_pkg::score_t out_score;
    logic            out_last;

    logic [31:0] lfsr_state;
    int          frame [nms_pkg::MAX_HEIGHT][nms_pkg::MAX_WIDTH];
    bit          win   [nms_pkg::MAX_HEIGHT][nms_pkg::MAX_WIDTH];
    int          exp_score_q [$];
    bit          exp_last_q [$];

    block_nms_top block_nms_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_valid  (cfg_valid),
        .cfg_width  (cfg_width),
        .cfg_height (cfg_height),
        .in_valid   (in_valid),
        .in_score   (in_score),
        .out_valid  (out_valid),
        .out_score  (out_score),
        .out_last   (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR time=%0t %s actual=%0h expected=%0h",
                               $time, name, actual, expected));
        end
    endtask

    // scores for one frame and the expected output in raster order
    task automatic build_frame(input case_t tc);
        int best;
        int by;
        int bx;
        for (int y = 0; y < tc.height; y++) begin
            for (int x = 0; x < tc.width; x++) begin
                case (tc.mode)
                    MODE_RANDOM: frame[y][x] = take_bits(8);
                    MODE_CONST:  frame[y][x] = tc.value;
                    default:     frame[y][x] = 0;
                endcase
                win[y][x] = 1'b0;
            end
        end
        for (int y0 = 0; y0 < tc.height; y0 += nms_pkg::BLOCK_SIZE) begin
            for (int x0 = 0; x0 < tc.width; x0 += nms_pkg::BLOCK_SIZE) begin
                best = 0;
                by   = y0;
                bx   = x0;
                // raster scan inside the block so the earliest max wins
                for (int y = y0; y < y0 + nms_pkg::BLOCK_SIZE; y++) begin
                    for (int x = x0; x < x0 + nms_pkg::BLOCK_SIZE && x < tc.width; x++) begin
                        if (frame[y][x] > best) begin
                            best = frame[y][x];
                            by   = y;
                            bx   = x;
                        end
                    end
                end
                if (best != 0) begin
                    win[by][bx] = 1'b1;
                end
            end
        end
        for (int y = 0; y < tc.height; y++) begin
            for (int x = 0; x < tc.width; x++) begin
                exp_score_q.push_back(win[y][x] ? frame[y][x] : 0);
                exp_last_q.push_back(y == tc.height - 1 && x == tc.width - 1);
            end
        end
    endtask

    task automatic configure_dut(input case_t tc);
        @(posedge clk);
        #2;
        cfg_valid  = 1'b1;
        cfg_width  = nms_pkg::col_t'(tc.width);
        cfg_height = nms_pkg::row_t'(tc.height);
        @(posedge clk);
        #2;
        cfg_valid = 1'b0;
    endtask

    task automatic drive_frame(input case_t tc);
        int idle;
        for (int y = 0; y < tc.height; y++) begin
            for (int x = 0; x < tc.width; x++) begin
                if (tc.gaps != 0) begin
                    idle = take_bits(2);
                    repeat (idle) begin
                        @(posedge clk);
                        #2;
                        in_valid = 1'b0;
                    end
                end
                @(posedge clk);
                #2;
                in_valid = 1'b1;
                in_score = nms_pkg::score_t'(frame[y][x]);
            end
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor and watchdog
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_score_q.size() == 0) begin
                fail_run("an output pixel arrived when none was expected");
            end else begin
                check_value("out_score", out_score, exp_score_q.pop_front());
                check_value("out_last", out_last, exp_last_q.pop_front());
            end
        end else if (rst_n) begin
            check_value("out_last", out_last, 0);
        end
    end

    initial begin
        int limit;
        limit = 1000;
        for (int c = 0; c < NUM_CASES; c++) begin
            limit += 4 * CASES[c].width * CASES[c].height;
        end
        repeat (limit) @(posedge clk);
        fail_run("timeout: the frames did not finish in time");
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        lfsr_state = 32'h17ab;
        rst_n      = 1'b0;
        cfg_valid  = 1'b0;
        cfg_width  = '0;
        cfg_height = '0;
        in_valid   = 1'b0;
        in_score   = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int c = 0; c < NUM_CASES; c++) begin
            // the previous band must drain before this frame's first band ends
            while (exp_score_q.size() > CASES[c].width * nms_pkg::BLOCK_SIZE) begin
                @(posedge clk);
            end
            build_frame(CASES[c]);
            configure_dut(CASES[c]);
            drive_frame(CASES[c]);
        end

        while (exp_score_q.size() != 0) begin
            @(posedge clk);
        end
        // catch any extra output
        repeat (20) @(posedge clk);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: src/band_drain.sv
module band_drain (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              band_done,
    input  logic              done_bank,
    input  logic              frame_end,
    input  nms_pkg::col_t     frame_width,
    input  nms_pkg::score_t   rd_score [2*nms_pkg::BLOCK_SIZE],
    input  nms_pkg::blk_off_t lk_row_off,
    input  nms_pkg::blk_off_t lk_col_off,
    input  nms_pkg::score_t   lk_score,
    output nms_pkg::col_t     rd_col,
    output logic              lk_bank,
    output nms_pkg::blk_col_t lk_blk,
    output logic              bank_free,
    output logic              free_bank,
    output logic              out_valid,
    output nms_pkg::score_t   out_score,
    output logic              out_last
);

    localparam int SEL_W = $clog2(2 * nms_pkg::BLOCK_SIZE);

    nms_pkg::drain_state_t state;
    logic                  bank_q;
    logic                  end_q;
    nms_pkg::col_t         width_q;
    nms_pkg::blk_off_t     row_q;
    nms_pkg::col_t         col_q;

    logic                  row_end;
    logic                  last_rd;
    logic                  start;
    logic                  hit;

    // read stage aligned with the buffer data
    logic                  rd_valid_q;
    logic                  rd_last_q;
    logic                  hit_q;
    logic [SEL_W-1:0]      sel_q;

    ////////////////////////////////////////////////////////////
    // read sequencing
    ////////////////////////////////////////////////////////////

    assign row_end = (col_q == width_q - 1'b1);
    assign last_rd = (state == nms_pkg::DRAIN_ROWS) && row_end
                     && (row_q == nms_pkg::blk_off_t'(nms_pkg::BLOCK_SIZE - 1));

    // the next band may land on the final read of this one
    assign start = band_done && ((state == nms_pkg::DRAIN_IDLE) || last_rd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= nms_pkg::DRAIN_IDLE;
            bank_q  <= 1'b0;
            end_q   <= 1'b0;
            width_q <= '0;
            row_q   <= '0;
            col_q   <= '0;
        end else if (start) begin
            state   <= nms_pkg::DRAIN_ROWS;
            bank_q  <= done_bank;
            end_q   <= frame_end;
            width_q <= frame_width;
            row_q   <= '0;
            col_q   <= '0;
        end else if (state == nms_pkg::DRAIN_ROWS) begin
            if (last_rd) begin
                state <= nms_pkg::DRAIN_IDLE;
            end else if (row_end) begin
                col_q <= '0;
                row_q <= row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    assign rd_col  = col_q;
    assign lk_bank = bank_q;
    assign lk_blk  = nms_pkg::blk_col_t'(col_q / nms_pkg::BLOCK_SIZE);

    // maxima of this bank are no longer needed after the last lookup
    assign bank_free = last_rd;
    assign free_bank = bank_q;

    // winner test at read issue time
    assign hit = (lk_score != '0) && (lk_row_off == row_q)
                 && (lk_col_off == nms_pkg::blk_off_t'(col_q));

    ////////////////////////////////////////////////////////////
    // output
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            rd_valid_q <= (state == nms_pkg::DRAIN_ROWS);
            rd_last_q  <= last_rd && end_q;
            out_valid  <= rd_valid_q;
            out_last   <= rd_valid_q && rd_last_q;
        end
    end

    always_ff @(posedge clk) begin
        hit_q     <= hit;
        sel_q     <= {bank_q, row_q};
        out_score <= hit_q ? rd_score[sel_q] : '0;
    end

    // bands must not overlap in the drain
    a_band_done_when_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        band_done |-> (state == nms_pkg::DRAIN_IDLE) || last_rd
    );

endmodule

// File: src/block_max_tracker.sv
module block_max_tracker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                trk_valid,
    input  logic                trk_bank,
    input  nms_pkg::col_t       trk_col,
    input  nms_pkg::blk_off_t   trk_row_off,
    input  nms_pkg::score_t     trk_score,
    input  logic                bank_free,
    input  logic                free_bank,
    input  logic                lk_bank,
    input  nms_pkg::blk_col_t   lk_blk,
    output nms_pkg::blk_off_t   lk_row_off,
    output nms_pkg::blk_off_t   lk_col_off,
    output nms_pkg::score_t     lk_score
);

    // best score and winner offsets per bank and block column
    nms_pkg::score_t   best_score [2][nms_pkg::NUM_BLOCK_COLS];
    nms_pkg::blk_off_t best_row   [2][nms_pkg::NUM_BLOCK_COLS];
    nms_pkg::blk_off_t best_col   [2][nms_pkg::NUM_BLOCK_COLS];

    nms_pkg::blk_col_t upd_blk;
    nms_pkg::blk_off_t upd_off;
    nms_pkg::score_t   cur_score;
    logic              clr_hit;
    logic              upd;

    // bank holds a full band until the drain frees it
    logic [1:0]        filled;

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    assign upd_blk = nms_pkg::blk_col_t'(trk_col / nms_pkg::BLOCK_SIZE);
    assign upd_off = nms_pkg::blk_off_t'(trk_col);

    // a clear on the same edge counts as an empty entry
    assign clr_hit   = bank_free && (free_bank == trk_bank);
    assign cur_score = clr_hit ? '0 : best_score[trk_bank][upd_blk];

    // strictly larger, so the earlier pixel keeps a tie
    assign upd = trk_valid && (trk_score > cur_score);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int k = 0; k < nms_pkg::NUM_BLOCK_COLS; k++) begin
                    best_score[b][k] <= '0;
                end
            end
        end else begin
            if (bank_free) begin
                for (int k = 0; k < nms_pkg::NUM_BLOCK_COLS; k++) begin
                    best_score[free_bank][k] <= '0;
                end
            end
            if (upd) begin
                best_score[trk_bank][upd_blk] <= trk_score;
            end
        end
    end

    // winner position follows every new best score
    always_ff @(posedge clk) begin
        if (upd) begin
            best_row[trk_bank][upd_blk] <= trk_row_off;
            best_col[trk_bank][upd_blk] <= upd_off;
        end
    end

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign lk_score   = best_score[lk_bank][lk_blk];
    assign lk_row_off = best_row[lk_bank][lk_blk];
    assign lk_col_off = best_col[lk_bank][lk_blk];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filled <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (bank_free && free_bank == b) begin
                    filled[b] <= 1'b0;
                end else if (trk_valid && trk_bank == b
                             && trk_row_off == nms_pkg::blk_off_t'(nms_pkg::BLOCK_SIZE - 1)) begin
                    filled[b] <= 1'b1;
                end
            end
        end
    end

    // a new band must not start in a bank the drain still holds
    a_no_refill_while_draining: assert property (
        @(posedge clk) disable iff (!rst_n)
        trk_valid && trk_row_off == '0 |-> !filled[trk_bank] || clr_hit
    );

endmodule

// File: src/block_nms_top.sv
module block_nms_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_valid,
    input  nms_pkg::col_t   cfg_width,
    input  nms_pkg::row_t   cfg_height,
    input  logic            in_valid,
    input  nms_pkg::score_t in_score,
    output logic            out_valid,
    output nms_pkg::score_t out_score,
    output logic            out_last
);

    // scanner side
    logic [2*nms_pkg::BLOCK_SIZE-1:0] wr_en;
    nms_pkg::col_t                     wr_col;
    nms_pkg::score_t                   wr_score;
    logic                              trk_valid;
    nms_pkg::blk_off_t                 trk_row_off;
    logic                              trk_bank;
    logic                              band_done;
    logic                              done_bank;
    logic                              frame_end;
    nms_pkg::col_t                     frame_width;

    // drain side
    nms_pkg::col_t                     rd_col;
    nms_pkg::score_t                   rd_score [2*nms_pkg::BLOCK_SIZE];
    logic                              lk_bank;
    nms_pkg::blk_col_t                 lk_blk;
    nms_pkg::blk_off_t                 lk_row_off;
    nms_pkg::blk_off_t                 lk_col_off;
    nms_pkg::score_t                   lk_score;
    logic                              bank_free;
    logic                              free_bank;

    frame_scanner frame_scanner_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid   (cfg_valid),
        .cfg_width   (cfg_width),
        .cfg_height  (cfg_height),
        .in_valid    (in_valid),
        .in_score    (in_score),
        .wr_en       (wr_en),
        .wr_col      (wr_col),
        .wr_score    (wr_score),
        .trk_valid   (trk_valid),
        .trk_row_off (trk_row_off),
        .trk_bank    (trk_bank),
        .band_done   (band_done),
        .done_bank   (done_bank),
        .frame_end   (frame_end),
        .frame_width (frame_width)
    );

    // two banks of BLOCK_SIZE rows each
    for (genvar i = 0; i < 2 * nms_pkg::BLOCK_SIZE; i++) begin : g_row_buf
        row_buffer row_buffer_i (
            .clk      (clk),
            .wr_en    (wr_en[i]),
            .wr_col   (wr_col),
            .wr_score (wr_score),
            .rd_col   (rd_col),
            .rd_score (rd_score[i])
        );
    end

    block_max_tracker block_max_tracker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .trk_valid   (trk_valid),
        .trk_bank    (trk_bank),
        .trk_col     (wr_col),
        .trk_row_off (trk_row_off),
        .trk_score   (wr_score),
        .bank_free   (bank_free),
        .free_bank   (free_bank),
        .lk_bank     (lk_bank),
        .lk_blk      (lk_blk),
        .lk_row_off  (lk_row_off),
        .lk_col_off  (lk_col_off),
        .lk_score    (lk_score)
    );

    band_drain band_drain_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .band_done   (band_done),
        .done_bank   (done_bank),
        .frame_end   (frame_end),
        .frame_width (frame_width),
        .rd_score    (rd_score),
        .lk_row_off  (lk_row_off),
        .lk_col_off  (lk_col_off),
        .lk_score    (lk_score),
        .rd_col      (rd_col),
        .lk_bank     (lk_bank),
        .lk_blk      (lk_blk),
        .bank_free   (bank_free),
        .free_bank   (free_bank),
        .out_valid   (out_valid),
        .out_score   (out_score),
        .out_last    (out_last)
    );

endmodule

// File: src/frame_scanner.sv
module frame_scanner (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cfg_valid,
    input  nms_pkg::col_t                     cfg_width,
    input  nms_pkg::row_t                     cfg_height,
    input  logic                              in_valid,
    input  nms_pkg::score_t                   in_score,
    output logic [2*nms_pkg::BLOCK_SIZE-1:0] wr_en,
    output nms_pkg::col_t                     wr_col,
    output nms_pkg::score_t                   wr_score,
    output logic                              trk_valid,
    output nms_pkg::blk_off_t                 trk_row_off,
    output logic                              trk_bank,
    output logic                              band_done,
    output logic                              done_bank,
    output logic                              frame_end,
    output nms_pkg::col_t                     frame_width
);

    logic          armed;
    nms_pkg::col_t width_q;
    nms_pkg::row_t height_q;
    nms_pkg::col_t x_cnt;
    nms_pkg::row_t y_cnt;
    logic          bank;

    logic accept;
    logic row_last;
    logic band_last;
    logic frame_last;

    ////////////////////////////////////////////////////////////
    // raster position
    ////////////////////////////////////////////////////////////

    assign accept      = in_valid && armed;
    assign trk_row_off = nms_pkg::blk_off_t'(y_cnt);

    assign row_last   = (x_cnt == width_q - 1'b1);
    assign band_last  = row_last && (trk_row_off == nms_pkg::blk_off_t'(nms_pkg::BLOCK_SIZE - 1));
    assign frame_last = band_last && (y_cnt == height_q - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed     <= 1'b0;
            width_q   <= '0;
            height_q  <= '0;
            x_cnt     <= '0;
            y_cnt     <= '0;
            bank      <= 1'b0;
            band_done <= 1'b0;
            done_bank <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            // new size only between frames
            if (cfg_valid && !armed) begin
                width_q  <= cfg_width;
                height_q <= cfg_height;
                armed    <= 1'b1;
            end

            band_done <= accept && band_last;
            if (accept && band_last) begin
                done_bank <= bank;
                frame_end <= frame_last;
            end

            if (accept) begin
                if (row_last) begin
                    x_cnt <= '0;
                    if (frame_last) begin
                        y_cnt <= '0;
                        armed <= 1'b0;
                    end else begin
                        y_cnt <= y_cnt + 1'b1;
                    end
                    // next band goes to the other bank
                    if (band_last) begin
                        bank <= ~bank;
                    end
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // write steering
    ////////////////////////////////////////////////////////////

    // buffer index is bank then row offset
    always_comb begin
        wr_en = '0;
        if (accept) begin
            wr_en[{bank, trk_row_off}] = 1'b1;
        end
    end

    assign wr_col      = x_cnt;
    assign wr_score    = in_score;
    assign trk_valid   = accept;
    assign trk_bank    = bank;
    assign frame_width = width_q;

    // scores only after a configuration
    a_input_needs_cfg: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> armed
    );

    // height must tile into whole bands
    a_cfg_size: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_valid && !armed |->
            cfg_height != '0 && (cfg_height % nms_pkg::BLOCK_SIZE) == 0
            && cfg_height <= nms_pkg::MAX_HEIGHT
            && cfg_width != '0 && cfg_width <= nms_pkg::MAX_WIDTH
    );

endmodule

// File: src/nms_pkg.sv
package nms_pkg;

    ////////////////////////////////////////////////////////////
    // frame and block geometry
    ////////////////////////////////////////////////////////////

    localparam int BLOCK_SIZE     = 4;
    localparam int MAX_WIDTH      = 64;
    localparam int MAX_HEIGHT     = 64;
    localparam int NUM_BLOCK_COLS = MAX_WIDTH / BLOCK_SIZE;

    ////////////////////////////////////////////////////////////
    // data and coordinate types
    ////////////////////////////////////////////////////////////

    typedef logic [7:0] score_t;

    // wide enough to hold MAX_WIDTH itself
    typedef logic [6:0] col_t;
    typedef logic [6:0] row_t;

    typedef logic [3:0] blk_col_t;
    typedef logic [1:0] blk_off_t;

    // output side FSM
    typedef enum logic {
        DRAIN_IDLE,
        DRAIN_ROWS
    } drain_state_t;

endpackage

// File: src/row_buffer.sv
module row_buffer (
    input  logic            clk,
    input  logic            wr_en,
    input  nms_pkg::col_t   wr_col,
    input  nms_pkg::score_t wr_score,
    input  nms_pkg::col_t   rd_col,
    output nms_pkg::score_t rd_score
);

    localparam int ADDR_W = $clog2(nms_pkg::MAX_WIDTH);

    // one image row of scores
    nms_pkg::score_t mem [nms_pkg::MAX_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_col[ADDR_W-1:0]] <= wr_score;
        end
    end

    // registered read with one cycle latency
    always_ff @(posedge clk) begin
        rd_score <= mem[rd_col[ADDR_W-1:0]];
    end

endmodule
